// ==== files.f ====
hw/cache_pkg.sv
hw/cache_way_if.sv
hw/cache_way.sv
hw/cache_ctrl.sv
hw/cache_top.sv
bench/clk_gen.sv
bench/mem_model.sv
bench/cache_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module cache_tb \
    -f files.f --Mdir obj_dir -o cache_tb_sim

./obj_dir/cache_tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
grep -q "TEST PASSED" sim.log

// ==== bench/cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb;
    import cache_pkg::*;

    localparam int   N_OPS      = 2000;
    localparam int   CLK_PERIOD = 4;
    localparam int   SEED       = 32'h59a34108;
    localparam tag_t TAG_BASE   = 20'h3c5a0;     // low 3 bits select the tag slot

    logic    clk, resetn;
    logic    valid, op, addr_ok, data_ok;
    index_t  index;
    tag_t    tag;
    offset_t offset;
    strb_t   wstrb;
    word_t   wdata, rdata, ret_data;
    logic    rd_req, rd_rdy, ret_valid, ret_last, wr_req, wr_rdy;
    addr_t   rd_addr, wr_addr;
    line_t   wr_data;

    // scoreboard state
    word_t   shadow [64];
    logic    exp_op_q [$];
    word_t   exp_word_q [$];
    int      pending, accepted, data_errors, proto_errors, seed;
    logic    head_op, seen_accept, rd_stalled;
    word_t   head_word;
    addr_t   prev_rd_addr, miss_addr;
    line_t   wb_line_exp;

    clk_gen #(.PERIOD_NS(CLK_PERIOD)) u_clk_gen (.clk(clk));

    mem_model #(.SEED(SEED)) u_mem (.*);

    cache_top u_cache_top (.*);

    function automatic index_t set_of(logic sel);
        return sel ? 8'hc7 : 8'h12;     // the two sets differ in bit 0
    endfunction

    // slot index is tag slot, set bit and bank
    function automatic logic [5:0] slot_of(addr_t a);
        return {a[14:12], a[4], a[3:2]};
    endfunction

    // must match the memory model fill
    function automatic word_t fill_word(addr_t a);
        return (a * 32'h9e3779b1) ^ 32'h6b43a9b5;
    endfunction

    function automatic word_t merge_bytes(word_t old, word_t data, strb_t strb);
        word_t res;
        res = old;
        for (int k = 0; k < 4; k++) begin
            if (strb[k]) begin
                res[k*8 +: 8] = data[k*8 +: 8];
            end
        end
        return res;
    endfunction

    always @(posedge clk) begin
        logic [5:0] s;
        s = slot_of({tag, index, offset});
        if (!resetn) begin
            for (int k = 0; k < 64; k++) begin
                shadow[k] <= fill_word({TAG_BASE + tag_t'(k / 8), set_of(k[2]), 2'(k), 2'b00});
            end
            exp_op_q.delete();
            exp_word_q.delete();
            pending     <= 0;
            accepted    <= 0;
            seen_accept <= 1'b0;
            rd_stalled  <= 1'b0;
        end else begin
            if (data_ok && exp_op_q.size() > 0) begin
                void'(exp_op_q.pop_front());
                void'(exp_word_q.pop_front());
            end
            if (valid && addr_ok) begin
                exp_op_q.push_back(op);
                exp_word_q.push_back(shadow[s]);    // value as seen by this load
                if (op) begin
                    shadow[s] <= merge_bytes(shadow[s], wdata, wstrb);
                end
                seen_accept <= 1'b1;
                accepted    <= accepted + 1;
                miss_addr   <= {tag, index, 4'h0};
            end
            pending <= exp_op_q.size();
            if (exp_op_q.size() > 0) begin
                head_op   <= exp_op_q[0];
                head_word <= exp_word_q[0];
            end
            rd_stalled   <= rd_req && !rd_rdy;
            prev_rd_addr <= rd_addr;
        end
    end

    always_comb begin
        for (int b = 0; b < BANKS; b++) begin
            wb_line_exp[b*WORD_W +: WORD_W] = shadow[{wr_addr[14:12], wr_addr[4], 2'(b)}];
        end
    end

    a_reset_quiet: assert property (@(posedge clk) disable iff (!resetn)
        !seen_accept |-> !data_ok && !rd_req && !wr_req)
        else begin
            proto_errors++;
            $display("output active after reset before any request at %0t", $time);
        end

    a_no_orphan: assert property (@(posedge clk) disable iff (!resetn)
        data_ok |-> pending != 0)
        else begin
            proto_errors++;
            $display("data_ok with no request pending at %0t", $time);
        end

    a_rdata: assert property (@(posedge clk) disable iff (!resetn)
        data_ok && pending != 0 && !head_op |-> rdata == head_word)
        else begin
            data_errors++;
            $display("Fail t=%0t rdata expected %h got %h", $time,
                $sampled(head_word), $sampled(rdata));
        end

    // victim sits in the missing set and holds another tag
    a_wb_addr: assert property (@(posedge clk) disable iff (!resetn)
        wr_req |-> wr_addr[3:0] == 4'h0 && wr_addr[11:4] == miss_addr[11:4]
            && wr_addr[31:12] != miss_addr[31:12])
        else begin
            data_errors++;
            $display("Fail t=%0t wr_addr expected set %h with a tag other than %h got %h",
                $time, $sampled(miss_addr[11:4]), $sampled(miss_addr[31:12]),
                $sampled(wr_addr));
        end

    a_wb_data: assert property (@(posedge clk) disable iff (!resetn)
        wr_req |-> wr_data == wb_line_exp)
        else begin
            data_errors++;
            $display("Fail t=%0t wr_data expected %h got %h", $time,
                $sampled(wb_line_exp), $sampled(wr_data));
        end

    a_rd_hold: assert property (@(posedge clk) disable iff (!resetn)
        rd_stalled |-> rd_req && rd_addr == prev_rd_addr)
        else begin
            proto_errors++;
            $display("rd_req or rd_addr changed while rd_rdy was low at %0t", $time);
        end

    a_rd_addr: assert property (@(posedge clk) disable iff (!resetn)
        rd_req |-> rd_addr == miss_addr)
        else begin
            data_errors++;
            $display("Fail t=%0t rd_addr expected %h got %h", $time,
                $sampled(miss_addr), $sampled(rd_addr));
        end

    // holds valid until addr_ok, then maybe idles a little
    task automatic send_random_request();
        int gap;
        valid  = 1'b1;
        op     = 1'($random(seed));
        index  = set_of(1'($random(seed)));
        tag    = TAG_BASE + tag_t'($unsigned($random(seed)) % 5);
        offset = {2'($random(seed)), 2'b00};
        wstrb  = 4'($random(seed));
        if (wstrb == 4'h0) begin
            wstrb = 4'h1;
        end
        wdata = $random(seed);
        @(negedge clk);
        while (!addr_ok) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        valid = 1'b0;
        gap   = int'($unsigned($random(seed)) % 8);
        if (gap > 5) begin
            repeat (gap - 5) @(posedge clk);
            #1;
        end
    endtask

    initial begin
        seed         = SEED;
        data_errors  = 0;
        proto_errors = 0;
        resetn       = 1'b0;
        valid        = 1'b0;
        op           = 1'b0;
        index        = '0;
        tag          = '0;
        offset       = '0;
        wstrb        = '0;
        wdata        = '0;
        repeat (4) @(posedge clk);
        #1;
        resetn = 1'b1;
        repeat (5) @(posedge clk);    // quiet outputs before the first request
        #1;
        for (int i = 0; i < N_OPS; i++) begin
            send_random_request();
        end
        while (pending != 0) begin
            @(posedge clk);
            #1;
        end
        repeat (20) @(posedge clk);
        $display("requests %0d, data errors %0d, protocol errors %0d",
            accepted, data_errors, proto_errors);
        if (data_errors == 0 && proto_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(N_OPS * 200 * CLK_PERIOD);
        $display("watchdog expired with %0d requests still pending", pending);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== bench/mem_model.sv ====
`timescale 1ns/1ps

module mem_model #(
    parameter int SEED = 1
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic              rd_req,
    input  cache_pkg::addr_t  rd_addr,
    output logic              rd_rdy,
    output logic              ret_valid,
    output logic              ret_last,
    output cache_pkg::word_t  ret_data,
    input  logic              wr_req,
    input  cache_pkg::addr_t  wr_addr,
    input  cache_pkg::line_t  wr_data,
    output logic              wr_rdy
);
    import cache_pkg::*;

    word_t mem [addr_t];    // written-back words only
    int    seed;
    int    beat;            // beats already returned for this line
    logic  busy;
    logic  live;
    addr_t line_addr;

    // untouched words come from the fill pattern
    function automatic word_t read_word(addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return (a * 32'h9e3779b1) ^ 32'h6b43a9b5;
    endfunction

    initial begin
        seed      = SEED;
        beat      = 0;
        busy      = 1'b0;
        line_addr = '0;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        wr_rdy    = 1'b0;
    end

    always @(posedge clk) begin
        live = resetn;
        if (!resetn) begin
            busy = 1'b0;
            beat = 0;
        end else begin
            if (wr_req) begin
                for (int b = 0; b < BANKS; b++) begin
                    mem[{wr_addr[31:4], 2'(b), 2'b00}] = wr_data[b*WORD_W +: WORD_W];
                end
            end
            if (ret_valid) begin
                beat = beat + 1;
                if (ret_last) begin
                    busy = 1'b0;
                end
            end
            if (rd_req && rd_rdy) begin
                busy      = 1'b1;   // line read accepted
                beat      = 0;
                line_addr = rd_addr;
            end
        end
        #1;
        rd_rdy    = live && !busy && (($random(seed) & 1) == 0);
        wr_rdy    = live && (($random(seed) & 3) != 0);
        ret_valid = busy && (($random(seed) & 3) != 0);    // gaps between beats
        ret_last  = ret_valid && beat == 3;
        ret_data  = ret_valid ? read_word({line_addr[31:4], 2'(beat), 2'b00}) : '0;
    end

endmodule

// ==== bench/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

// ==== hw/cache_top.sv ====
`timescale 1ns/1ps

module cache_top #(
    parameter logic [7:0] LFSR_SEED = 8'd1
) (
    input  logic                clk,
    input  logic                resetn,
    // cpu side
    input  logic                valid,
    input  logic                op,
    input  cache_pkg::index_t   index,
    input  cache_pkg::tag_t     tag,
    input  cache_pkg::offset_t  offset,
    input  cache_pkg::strb_t    wstrb,
    input  cache_pkg::word_t    wdata,
    output logic                addr_ok,
    output logic                data_ok,
    output cache_pkg::word_t    rdata,
    // line read port
    output logic                rd_req,
    output cache_pkg::addr_t    rd_addr,
    input  logic                rd_rdy,
    input  logic                ret_valid,
    input  logic                ret_last,
    input  cache_pkg::word_t    ret_data,
    // line write port
    output logic                wr_req,
    output cache_pkg::addr_t    wr_addr,
    output cache_pkg::line_t    wr_data,
    input  logic                wr_rdy
);

    cache_way_if way0_if ();
    cache_way_if way1_if ();

    cache_way u_way0 (
        .clk    (clk),
        .resetn (resetn),
        .port   (way0_if.way)
    );

    cache_way u_way1 (
        .clk    (clk),
        .resetn (resetn),
        .port   (way1_if.way)
    );

    cache_ctrl #(
        .LFSR_SEED (LFSR_SEED)
    ) u_ctrl (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .op        (op),
        .index     (index),
        .tag       (tag),
        .offset    (offset),
        .wstrb     (wstrb),
        .wdata     (wdata),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy),
        .way0      (way0_if.ctrl),
        .way1      (way1_if.ctrl)
    );

endmodule

// ==== hw/cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl #(
    parameter logic [7:0] LFSR_SEED = 8'd1
) (
    input  logic                clk,
    input  logic                resetn,
    // cpu side
    input  logic                valid,
    input  logic                op,
    input  cache_pkg::index_t   index,
    input  cache_pkg::tag_t     tag,
    input  cache_pkg::offset_t  offset,
    input  cache_pkg::strb_t    wstrb,
    input  cache_pkg::word_t    wdata,
    output logic                addr_ok,
    output logic                data_ok,
    output cache_pkg::word_t    rdata,
    // line read port
    output logic                rd_req,
    output cache_pkg::addr_t    rd_addr,
    input  logic                rd_rdy,
    input  logic                ret_valid,
    input  logic                ret_last,
    input  cache_pkg::word_t    ret_data,
    // line write port
    output logic                wr_req,
    output cache_pkg::addr_t    wr_addr,
    output cache_pkg::line_t    wr_data,
    input  logic                wr_rdy,
    // ways
    cache_way_if.ctrl           way0,
    cache_way_if.ctrl           way1
);
    import cache_pkg::*;

    main_state_t main_state;
    main_state_t main_next;
    wbuf_state_t wb_state;
    wbuf_state_t wb_next;

    // request buffer
    logic   req_op;
    index_t req_index;
    tag_t   req_tag;
    bank_t  req_bank;
    strb_t  req_wstrb;
    word_t  req_wdata;

    // write buffer
    logic   wb_way;
    index_t wb_index;
    bank_t  wb_bank;
    strb_t  wb_wstrb;
    word_t  wb_wdata;

    logic [1:0] hit_w;
    logic [1:0] valid_w;
    logic [1:0] dirty_w;
    tag_t       tag_w [2];
    line_t      line_w [2];

    logic   cache_hit;
    logic   hit_way;
    bank_t  in_bank;
    logic   conflict;
    logic   accept;
    logic   hit_write;
    logic   refill_beat;
    logic   refill_done;
    logic   first_replace;
    bank_t  refill_cnt;
    logic [7:0] lfsr;
    logic   victim;
    word_t  load_word;
    word_t  store_mask;
    word_t  fill_word;

    index_t             rd_index;
    index_t [BANKS-1:0] bank_index;
    strb_t  [BANKS-1:0] bank_wen [2];
    word_t              bank_wdata;
    logic [1:0]         tagv_wen;
    logic [1:0]         dirty_wen;
    index_t             dirty_index;
    logic               dirty_wdata;

    assign hit_w     = {way1.hit, way0.hit};
    assign valid_w   = {way1.valid, way0.valid};
    assign dirty_w   = {way1.dirty, way0.dirty};
    assign tag_w[0]  = way0.tag;
    assign tag_w[1]  = way1.tag;
    assign line_w[0] = way0.line;
    assign line_w[1] = way1.line;

    assign cache_hit = |hit_w;
    assign hit_way   = ~hit_w[0];
    assign load_word = line_w[hit_way][int'(req_bank)*WORD_W +: WORD_W];
    assign in_bank   = offset[OFFSET_W-1:2];

    // a load must not read a word with a store still in flight
    assign conflict = ~op & (
          (main_state == LOOKUP && req_op
              && {tag, index, in_bank} == {req_tag, req_index, req_bank})
        | (wb_state == WB_WRITE && in_bank == wb_bank));

    assign addr_ok     = (main_state == IDLE || (main_state == LOOKUP && cache_hit)) & ~conflict;
    assign accept      = valid & addr_ok;
    assign hit_write   = main_state == LOOKUP && cache_hit && req_op;
    assign refill_beat = main_state == REFILL && ret_valid;
    assign refill_done = refill_beat & ret_last;

    assign data_ok = (main_state == LOOKUP && (cache_hit || req_op))     // hit, or write miss
                   | (refill_beat && !req_op && refill_cnt == req_bank); // read miss word
    assign rdata   = (main_state == LOOKUP) ? load_word : ret_data;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            main_state <= IDLE;
        end else begin
            main_state <= main_next;
        end
    end

    always_comb begin
        main_next = main_state;
        case (main_state)
            IDLE:    if (accept) main_next = LOOKUP;
            LOOKUP: begin
                if (accept) begin
                    main_next = LOOKUP;
                end else if (!cache_hit) begin
                    main_next = MISS;
                end else begin
                    main_next = IDLE;
                end
            end
            MISS:    if (wr_rdy) main_next = REPLACE;
            REPLACE: if (rd_rdy) main_next = REFILL;
            REFILL:  if (refill_done) main_next = IDLE;
            default: main_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_state <= WB_IDLE;
        end else begin
            wb_state <= wb_next;
        end
    end

    always_comb begin
        case (wb_state)
            WB_IDLE:  wb_next = hit_write ? WB_WRITE : WB_IDLE;
            WB_WRITE: wb_next = hit_write ? WB_WRITE : WB_IDLE;  // back to back stores
            default:  wb_next = WB_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_op    <= op;
            req_index <= index;
            req_tag   <= tag;
            req_bank  <= in_bank;
            req_wstrb <= wstrb;
            req_wdata <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (hit_write) begin
            wb_way   <= hit_way;
            wb_index <= req_index;
            wb_bank  <= req_bank;
            wb_wstrb <= req_wstrb;
            wb_wdata <= req_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            refill_cnt <= '0;
        end else if (refill_done) begin
            refill_cnt <= '0;
        end else if (refill_beat) begin
            refill_cnt <= refill_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            first_replace <= 1'b0;
        end else begin
            first_replace <= main_state == MISS && wr_rdy;
        end
    end

    // victim pick advances once per refill
    always_ff @(posedge clk) begin
        if (!resetn) begin
            lfsr <= LFSR_SEED;
        end else if (refill_done) begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end
    end

    assign victim = lfsr[0];

    // store merge for a write miss
    always_comb begin
        for (int k = 0; k < WORD_W / 8; k++) begin
            store_mask[k*8 +: 8] = {8{req_wstrb[k]}};
        end
    end

    assign fill_word = (req_op && refill_cnt == req_bank)
                     ? ((req_wdata & store_mask) | (ret_data & ~store_mask))
                     : ret_data;

    // follow the next request only while a hit lets it in, else hold own set
    assign rd_index = (main_state == IDLE || (main_state == LOOKUP && cache_hit))
                    ? index : req_index;

    always_comb begin
        for (int b = 0; b < BANKS; b++) begin
            bank_index[b] = (wb_state == WB_WRITE && wb_bank == b) ? wb_index : rd_index;
        end
        for (int w = 0; w < 2; w++) begin
            for (int b = 0; b < BANKS; b++) begin
                if (wb_state == WB_WRITE && wb_way == w && wb_bank == b) begin
                    bank_wen[w][b] = wb_wstrb;
                end else if (refill_beat && victim == w && refill_cnt == b) begin
                    bank_wen[w][b] = '1;
                end else begin
                    bank_wen[w][b] = '0;
                end
            end
            tagv_wen[w]  = refill_done && victim == w;
            dirty_wen[w] = (wb_state == WB_WRITE && wb_way == w) || (refill_done && victim == w);
        end
    end

    // store commit and refill never overlap
    assign bank_wdata  = (wb_state == WB_WRITE) ? wb_wdata : fill_word;
    assign dirty_index = (wb_state == WB_WRITE) ? wb_index : req_index;
    assign dirty_wdata = (wb_state == WB_WRITE) | req_op;

    assign way0.rd_index    = rd_index;
    assign way0.bank_index  = bank_index;
    assign way0.bank_wen    = bank_wen[0];
    assign way0.bank_wdata  = bank_wdata;
    assign way0.cmp_tag     = req_tag;
    assign way0.tagv_wen    = tagv_wen[0];
    assign way0.tagv_wdata  = req_tag;
    assign way0.dirty_wen   = dirty_wen[0];
    assign way0.dirty_index = dirty_index;
    assign way0.dirty_wdata = dirty_wdata;

    assign way1.rd_index    = rd_index;
    assign way1.bank_index  = bank_index;
    assign way1.bank_wen    = bank_wen[1];
    assign way1.bank_wdata  = bank_wdata;
    assign way1.cmp_tag     = req_tag;
    assign way1.tagv_wen    = tagv_wen[1];
    assign way1.tagv_wdata  = req_tag;
    assign way1.dirty_wen   = dirty_wen[1];
    assign way1.dirty_index = dirty_index;
    assign way1.dirty_wdata = dirty_wdata;

    // victim line is reread in MISS, so REPLACE sees any committed store
    assign wr_req  = first_replace & valid_w[victim] & dirty_w[victim];
    assign wr_addr = {tag_w[victim], req_index, {OFFSET_W{1'b0}}};
    assign wr_data = line_w[victim];

    assign rd_req  = main_state == REPLACE;
    assign rd_addr = {req_tag, req_index, {OFFSET_W{1'b0}}};   // whole line

endmodule

// ==== hw/cache_way.sv ====
`timescale 1ns/1ps

module cache_way (
    input  logic      clk,
    input  logic      resetn,
    cache_way_if.way  port
);
    import cache_pkg::*;

    localparam int SETS = 1 << INDEX_W;

    tag_t            tag_mem [SETS];
    logic [SETS-1:0] valid_vec;
    logic [SETS-1:0] dirty_vec;

    tag_t  tag_q;
    logic  valid_q;
    logic  dirty_q;
    word_t line_q [BANKS];      // one read register per bank

    // each data bank has its own index so a store can overlap a lookup
    for (genvar b = 0; b < BANKS; b++) begin : g_bank
        word_t mem [SETS];

        always_ff @(posedge clk) begin
            for (int k = 0; k < WORD_W / 8; k++) begin
                if (port.bank_wen[b][k]) begin
                    mem[port.bank_index[b]][k*8 +: 8] <= port.bank_wdata[k*8 +: 8];
                end
            end
            line_q[b] <= mem[port.bank_index[b]];   // old data on same-cycle write
        end
    end

    always_comb begin
        for (int b = 0; b < BANKS; b++) begin
            port.line[b*WORD_W +: WORD_W] = line_q[b];
        end
    end

    // tag store is written only on the last refill beat
    always_ff @(posedge clk) begin
        if (port.tagv_wen) begin
            tag_mem[port.rd_index] <= port.tagv_wdata;
        end
        tag_q <= tag_mem[port.rd_index];
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_vec <= '0;
        end else if (port.tagv_wen) begin
            valid_vec[port.rd_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            dirty_vec <= '0;
        end else if (port.dirty_wen) begin
            dirty_vec[port.dirty_index] <= port.dirty_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= 1'b0;
            dirty_q <= 1'b0;
        end else begin
            valid_q <= valid_vec[port.rd_index];
            dirty_q <= dirty_vec[port.rd_index];
        end
    end

    // compare against the buffered request tag
    assign port.hit   = valid_q && (tag_q == port.cmp_tag);
    assign port.tag   = tag_q;
    assign port.valid = valid_q;
    assign port.dirty = dirty_q;

endmodule

// ==== hw/cache_way_if.sv ====
`timescale 1ns/1ps

interface cache_way_if;
    import cache_pkg::*;

    // lookup and storage control from the controller
    index_t             rd_index;       // tag/valid/dirty read, tag/valid write
    index_t [BANKS-1:0] bank_index;
    strb_t  [BANKS-1:0] bank_wen;
    word_t              bank_wdata;
    tag_t               cmp_tag;
    logic               tagv_wen;
    tag_t               tagv_wdata;     // valid is set along with it
    logic               dirty_wen;
    index_t             dirty_index;    // hit store and refill use different sets
    logic               dirty_wdata;

    // registered read results from the way
    logic               hit;
    line_t              line;
    tag_t               tag;
    logic               dirty;
    logic               valid;

    modport ctrl (
        output rd_index, bank_index, bank_wen, bank_wdata, cmp_tag,
        output tagv_wen, tagv_wdata, dirty_wen, dirty_index, dirty_wdata,
        input  hit, line, tag, dirty, valid
    );

    modport way (
        input  rd_index, bank_index, bank_wen, bank_wdata, cmp_tag,
        input  tagv_wen, tagv_wdata, dirty_wen, dirty_index, dirty_wdata,
        output hit, line, tag, dirty, valid
    );

endinterface

// ==== hw/cache_pkg.sv ====
package cache_pkg;

    // tag, index and offset widths of a byte address
    localparam int INDEX_W  = 8;
    localparam int TAG_W    = 20;
    localparam int OFFSET_W = 4;

    localparam int WORD_W = 32;
    localparam int BANKS  = 4;                  // words per line
    localparam int LINE_W = WORD_W * BANKS;

    typedef logic [INDEX_W-1:0]                  index_t;
    typedef logic [TAG_W-1:0]                    tag_t;
    typedef logic [OFFSET_W-1:0]                 offset_t;
    typedef logic [OFFSET_W-3:0]                 bank_t;    // word within line
    typedef logic [WORD_W-1:0]                   word_t;
    typedef logic [WORD_W/8-1:0]                 strb_t;
    typedef logic [LINE_W-1:0]                   line_t;
    typedef logic [TAG_W+INDEX_W+OFFSET_W-1:0]   addr_t;

    // main pipeline
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REPLACE,
        REFILL
    } main_state_t;

    // hit store commit
    typedef enum logic {
        WB_IDLE,
        WB_WRITE
    } wbuf_state_t;

endpackage
